//--- Makefile
VERILATOR  = verilator
TOP        = uart_alu_tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = TEST FAILED
LINT_FLAGS = --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  uart_alu_pkg::alu_command_t          i_command,
    input  logic                                i_command_valid,
    output logic [uart_alu_pkg::data_width-1:0] o_result,
    output logic                                o_result_valid
);

    import uart_alu_pkg::*;

    localparam int shift_width = $clog2(data_width);

    logic [data_width-1:0]  result_next;
    logic [shift_width-1:0] shift_amount;

    assign shift_amount = i_command.operand_b[shift_width-1:0]; // B modulo 8.

    always_comb begin
        case (i_command.opcode)
            op_add:  result_next = i_command.operand_a + i_command.operand_b;
            op_sub:  result_next = i_command.operand_a - i_command.operand_b;
            op_and:  result_next = i_command.operand_a & i_command.operand_b;
            op_or:   result_next = i_command.operand_a | i_command.operand_b;
            op_xor:  result_next = i_command.operand_a ^ i_command.operand_b;
            op_nor:  result_next = ~(i_command.operand_a | i_command.operand_b);
            op_srl:  result_next = i_command.operand_a >> shift_amount;
            op_sra:  result_next = $signed(i_command.operand_a) >>> shift_amount;
            default: result_next = '0; // Unknown opcode.
        endcase
    end

    // Output stage.
    always_ff @(posedge i_clock) begin
        if (!i_reset) o_result_valid <= 1'b0;
        else          o_result_valid <= i_command_valid;
    end

    always_ff @(posedge i_clock) begin
        if (i_command_valid) o_result <= result_next;
    end

endmodule

//--- rtl/command_assembler.sv
`timescale 1ns/1ps

module command_assembler (
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  logic [uart_alu_pkg::data_width-1:0] i_rx_byte,
    input  logic                                i_rx_valid,
    input  logic                                i_tx_done,
    output uart_alu_pkg::alu_command_t          o_command,
    output logic                                o_command_valid
);

    import uart_alu_pkg::*;

    // One-hot. One state per expected byte plus the wait for the reply.
    typedef enum logic [3:0] {
        st_wait_a  = 4'b0001,
        st_wait_op = 4'b0010,
        st_wait_b  = 4'b0100,
        st_wait_tx = 4'b1000
    } asm_state_t;

    asm_state_t state;

    ////////////////////////////////////////
    // Sequencing.
    ////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state           <= st_wait_a;
            o_command_valid <= 1'b0;
        end else begin
            o_command_valid <= 1'b0;
            case (state)
                st_wait_a: begin
                    if (i_rx_valid) state <= st_wait_op;
                end
                st_wait_op: begin
                    if (i_rx_valid) state <= st_wait_b;
                end
                st_wait_b: begin
                    if (i_rx_valid) begin
                        state           <= st_wait_tx;
                        o_command_valid <= 1'b1; // Command complete.
                    end
                end
                st_wait_tx: begin
                    // Bytes arriving now are dropped.
                    if (i_tx_done) state <= st_wait_a;
                end
                default: state <= st_wait_a;
            endcase
        end
    end

    // Each field loads on the pulse that carries it.
    always_ff @(posedge i_clock) begin
        if (i_rx_valid) begin
            case (state)
                st_wait_a:  o_command.operand_a <= i_rx_byte;
                st_wait_op: o_command.opcode    <= alu_op_t'(i_rx_byte);
                st_wait_b:  o_command.operand_b <= i_rx_byte;
                default: ; // Held for the ALU.
            endcase
        end
    end

endmodule

//--- rtl/uart_alu_pkg.sv
package uart_alu_pkg;

    ////////////////////////////////////////
    // Word size.
    ////////////////////////////////////////

    // One serial byte, one ALU operand.
    localparam int data_width = 8;

    ////////////////////////////////////////
    // Opcodes.
    ////////////////////////////////////////

    // The second byte of every command frame.
    // Any other value is legal on the line and gives a zero result.
    typedef enum logic [data_width-1:0] {
        op_add = 8'h20, // A plus B.
        op_sub = 8'h22, // A minus B.
        op_and = 8'h24,
        op_or  = 8'h25,
        op_xor = 8'h26,
        op_nor = 8'h27,
        op_srl = 8'h02, // A shifted right, zero fill.
        op_sra = 8'h03  // A shifted right, sign fill.
    } alu_op_t;

    ////////////////////////////////////////
    // Command.
    ////////////////////////////////////////

    // Fields in frame order with operand A first.
    typedef struct packed {
        logic [data_width-1:0] operand_a;
        alu_op_t               opcode;
        logic [data_width-1:0] operand_b; // Shift amount for srl and sra.
    } alu_command_t;

endpackage

//--- rtl/uart_alu_top.sv
`timescale 1ns/1ps

module uart_alu_top #(
    parameter int unsigned clocks_per_bit = 16 // Clock cycles per serial bit.
) (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx,
    output logic o_tx_busy
);

    import uart_alu_pkg::*;

    logic [data_width-1:0] rx_byte;
    logic                  rx_valid;
    alu_command_t          command;
    logic                  command_valid;
    logic [data_width-1:0] result;
    logic                  result_valid;
    logic                  tx_done;

    ////////////////////////////////////////
    // Receive and assemble.
    ////////////////////////////////////////

    uart_receiver #(
        .clocks_per_bit(clocks_per_bit)
    ) uart_receiver_inst (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rx      (i_rx),
        .o_rx_byte (rx_byte),
        .o_rx_valid(rx_valid)
    );

    command_assembler command_assembler_inst (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_rx_byte      (rx_byte),
        .i_rx_valid     (rx_valid),
        .i_tx_done      (tx_done), // Releases the next frame.
        .o_command      (command),
        .o_command_valid(command_valid)
    );

    ////////////////////////////////////////
    // Compute and reply.
    ////////////////////////////////////////

    alu alu_inst (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_command      (command),
        .i_command_valid(command_valid),
        .o_result       (result),
        .o_result_valid (result_valid)
    );

    uart_transmitter #(
        .clocks_per_bit(clocks_per_bit)
    ) uart_transmitter_inst (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_tx_data (result),
        .i_tx_start(result_valid),
        .o_tx      (o_tx),
        .o_tx_busy (o_tx_busy),
        .o_tx_done (tx_done)
    );

endmodule

//--- rtl/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver #(
    parameter int unsigned clocks_per_bit = 16
) (
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  logic                                i_rx,
    output logic [uart_alu_pkg::data_width-1:0] o_rx_byte,
    output logic                                o_rx_valid
);

    import uart_alu_pkg::*;

    localparam int count_width = $clog2(clocks_per_bit);
    localparam int index_width = $clog2(data_width);

    localparam logic [count_width-1:0] last_count = count_width'(clocks_per_bit - 1);
    localparam logic [count_width-1:0] half_count = count_width'(clocks_per_bit / 2 - 1);
    localparam logic [index_width-1:0] last_index = index_width'(data_width - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t              state;
    logic                   rx_meta;
    logic                   rx_sync;
    logic [count_width-1:0] bit_count;
    logic [index_width-1:0] bit_index;
    logic [data_width-1:0]  shift_reg;
    logic                   sample_data;
    logic                   sample_stop;

    // Middle of a data bit and of the stop bit.
    assign sample_data = (state == st_data) && (bit_count == last_count);
    assign sample_stop = (state == st_stop) && (bit_count == last_count);

    ////////////////////////////////////////
    // Frame control.
    ////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_meta    <= 1'b1; // Idle line is high.
            rx_sync    <= 1'b1;
            state      <= st_idle;
            bit_count  <= '0;
            bit_index  <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rx_meta    <= i_rx;
            rx_sync    <= rx_meta;
            o_rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    bit_count <= '0;
                    bit_index <= '0;
                    if (!rx_sync) state <= st_start;
                end
                st_start: begin
                    if (bit_count == half_count) begin
                        bit_count <= '0;
                        // A start bit gone high by its middle is noise.
                        state     <= rx_sync ? st_idle : st_data;
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end
                st_data: begin
                    if (sample_data) begin
                        bit_count <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == last_index) state <= st_stop;
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end
                st_stop: begin
                    if (sample_stop) begin
                        o_rx_valid <= rx_sync; // Framing error drops the byte.
                        state      <= st_idle;
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Data path. LSB arrives first.
    always_ff @(posedge i_clock) begin
        if (sample_data) shift_reg <= {rx_sync, shift_reg[data_width-1:1]};
        if (sample_stop && rx_sync) o_rx_byte <= shift_reg;
    end

endmodule

//--- rtl/uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter #(
    parameter int unsigned clocks_per_bit = 16
) (
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  logic [uart_alu_pkg::data_width-1:0] i_tx_data,
    input  logic                                i_tx_start,
    output logic                                o_tx,
    output logic                                o_tx_busy,
    output logic                                o_tx_done
);

    import uart_alu_pkg::*;

    localparam int count_width = $clog2(clocks_per_bit);
    localparam int index_width = $clog2(data_width);

    localparam logic [count_width-1:0] last_count = count_width'(clocks_per_bit - 1);
    localparam logic [index_width-1:0] last_index = index_width'(data_width - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_t;

    tx_state_t              state;
    logic [count_width-1:0] bit_count;
    logic [index_width-1:0] bit_index;
    logic [data_width-1:0]  shift_reg;
    logic                   bit_end;

    assign bit_end   = (bit_count == last_count);
    assign o_tx_busy = (state != st_idle);
    assign o_tx_done = (state == st_stop) && bit_end; // Last cycle of the stop bit.

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state     <= st_idle;
            bit_count <= '0;
            bit_index <= '0;
            o_tx      <= 1'b1;
        end else begin
            bit_count <= bit_end ? '0 : bit_count + 1'b1;
            case (state)
                st_idle: begin
                    bit_count <= '0;
                    bit_index <= '0;
                    o_tx      <= 1'b1;
                    if (i_tx_start) begin
                        state <= st_start;
                        o_tx  <= 1'b0; // Start bit.
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        state <= st_data;
                        o_tx  <= shift_reg[0];
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == last_index) begin
                            state <= st_stop;
                            o_tx  <= 1'b1; // Stop bit.
                        end else begin
                            o_tx <= shift_reg[0];
                        end
                    end
                end
                st_stop: begin
                    if (bit_end) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Byte latch. Shifts as each bit goes out.
    always_ff @(posedge i_clock) begin
        if ((state == st_idle) && i_tx_start) begin
            shift_reg <= i_tx_data;
        end else if (((state == st_start) || (state == st_data)) && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

//--- tb.f
rtl/uart_alu_pkg.sv
rtl/uart_receiver.sv
rtl/command_assembler.sv
rtl/alu.sv
rtl/uart_transmitter.sv
rtl/uart_alu_top.sv
tb/tb_clock_gen.sv
tb/uart_alu_properties.sv
tb/uart_alu_tb.sv

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int unsigned half_period_ns = 10 // 20 ns period.
) (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
        forever #(half_period_ns) o_clock = ~o_clock;
    end

endmodule

//--- tb/uart_alu_properties.sv
`timescale 1ns/1ps

module uart_alu_properties (
    input logic i_clock,
    input logic i_reset,
    input logic i_tx,
    input logic i_tx_busy,
    input logic i_rx_valid,
    input logic i_command_valid,
    input logic i_result_valid,
    input logic i_tx_done
);

    ////////////////////////////////////////
    // Serial line.
    ////////////////////////////////////////

    tx_idle_high: assert property (@(posedge i_clock) disable iff (!i_reset)
        !i_tx_busy |-> i_tx)
        else $error("Transmit line low while the transmitter is idle.");

    ////////////////////////////////////////
    // Stage handshakes.
    ////////////////////////////////////////

    // Every valid is a single-cycle pulse.
    rx_valid_pulse: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_rx_valid |=> !i_rx_valid)
        else $error("Receive valid high for two cycles.");

    command_valid_pulse: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_command_valid |=> !i_command_valid)
        else $error("Command valid high for two cycles.");

    result_valid_pulse: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_result_valid |=> !i_result_valid)
        else $error("Result valid high for two cycles.");

    tx_done_pulse: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_tx_done |=> !i_tx_done)
        else $error("Transmit done high for two cycles.");

    alu_latency: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_command_valid |=> i_result_valid)
        else $error("ALU result did not follow the command by one cycle.");

    no_command_while_busy: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_command_valid |-> !i_tx_busy)
        else $error("Command issued while the transmitter is busy.");

endmodule

bind uart_alu_top uart_alu_properties uart_alu_properties_inst (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_tx           (o_tx),
    .i_tx_busy      (o_tx_busy),
    .i_rx_valid     (rx_valid),
    .i_command_valid(command_valid),
    .i_result_valid (result_valid),
    .i_tx_done      (tx_done)
);

//--- tb/uart_alu_tb.sv
`timescale 1ns/1ps

module uart_alu_tb;

    import uart_alu_pkg::*;

    localparam int unsigned clocks_per_bit = 16;
    localparam int unsigned drive_delay    = 2; // ns after the rising edge.
    localparam int unsigned timeout_cycles = 40 * 4 * 10 * clocks_per_bit * 2;

    logic        clock;
    logic        reset;
    logic        rx;
    logic        tx;
    logic        tx_busy;
    int unsigned error_count = 0;
    int unsigned check_count = 0;
    int unsigned cycle_count = 0;
    logic [31:0] lcg_state   = 32'hb440;

    tb_clock_gen tb_clock_gen_inst (.o_clock(clock));

    uart_alu_top #(
        .clocks_per_bit(clocks_per_bit)
    ) uart_alu_top_inst (
        .i_clock  (clock),
        .i_reset  (reset),
        .i_rx     (rx),
        .o_tx     (tx),
        .o_tx_busy(tx_busy)
    );

    // Run limit.
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles.", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Models.
    ////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] opcode_from_index(logic [2:0] index);
        case (index)
            3'd0:    return 8'h20;
            3'd1:    return 8'h22;
            3'd2:    return 8'h24;
            3'd3:    return 8'h25;
            3'd4:    return 8'h26;
            3'd5:    return 8'h27;
            3'd6:    return 8'h02;
            default: return 8'h03;
        endcase
    endfunction

    function automatic logic [7:0] reference_result(logic [7:0] a, logic [7:0] op, logic [7:0] b);
        logic [2:0] amount;
        logic [7:0] sign_fill;
        amount    = b[2:0];
        sign_fill = ~(8'hff >> amount); // Ones in the vacated top bits.
        case (op)
            8'h20:   return a + b;
            8'h22:   return a - b;
            8'h24:   return a & b;
            8'h25:   return a | b;
            8'h26:   return a ^ b;
            8'h27:   return ~(a | b);
            8'h02:   return a >> amount;
            8'h03:   return (a >> amount) | (a[7] ? sign_fill : 8'h00);
            default: return 8'h00;
        endcase
    endfunction

    ////////////////////////////////////////
    // Serial driver and monitor.
    ////////////////////////////////////////

    task automatic send_bit(logic value);
        rx = value;
        repeat (clocks_per_bit) @(posedge clock);
        #(drive_delay);
    endtask

    task automatic send_byte(logic [7:0] data, logic stop_level);
        @(posedge clock);
        #(drive_delay);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) send_bit(data[i]); // LSB first.
        send_bit(stop_level);
    endtask

    task automatic send_frame(logic [7:0] a, logic [7:0] op, logic [7:0] b);
        send_byte(a, 1'b1);
        send_byte(op, 1'b1);
        send_byte(b, 1'b1);
    endtask

    task automatic receive_byte(output logic [7:0] data);
        data = '0;
        @(negedge tx);
        repeat (clocks_per_bit / 2) @(negedge clock); // Middle of the start bit.
        if (tx !== 1'b0) begin
            error_count++;
            $display("Reply start bit was not low at its middle, time %0t.", $time);
        end
        for (int i = 0; i < 8; i++) begin
            repeat (clocks_per_bit) @(negedge clock);
            data[i] = tx;
        end
        repeat (clocks_per_bit) @(negedge clock);
        if (tx !== 1'b1) begin
            error_count++;
            $display("Reply had a bad stop bit, time %0t.", $time);
        end
    endtask

    // Sends one command and checks the reply against the model.
    task automatic run_frame(string label, logic [7:0] a, logic [7:0] op, logic [7:0] b);
        logic [7:0] expected;
        logic [7:0] actual;
        expected = reference_result(a, op, b);
        fork
            send_frame(a, op, b);
            receive_byte(actual);
        join
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t %s frame a=%02h op=%02h b=%02h expected %02h got %02h",
                     $time, label, a, op, b, expected, actual);
        end
        while (tx_busy !== 1'b0) @(negedge clock);
    endtask

    ////////////////////////////////////////
    // Directed tests.
    ////////////////////////////////////////

    task automatic check_reset_state();
        @(negedge clock);
        check_count++;
        if (tx !== 1'b1 || tx_busy !== 1'b0) begin
            error_count++;
            $display("[FAIL] %0t reset state tx=%b busy=%b expected tx=1 busy=0",
                     $time, tx, tx_busy);
        end
    endtask

    task automatic opcode_sweep();
        run_frame("add", 8'hff, op_add, 8'h01); // Wraps to zero.
        run_frame("sub", 8'h00, op_sub, 8'h01);
        run_frame("and", 8'hff, op_and, 8'h80);
        run_frame("or",  8'h80, op_or,  8'h00);
        run_frame("xor", 8'hff, op_xor, 8'h80);
        run_frame("nor", 8'h00, op_nor, 8'h00);
        run_frame("srl", 8'h80, op_srl, 8'h07);
        run_frame("sra", 8'h80, op_sra, 8'h07);
        run_frame("srl", 8'hff, op_srl, 8'h0f); // Amount taken modulo 8.
        run_frame("sra", 8'h7f, op_sra, 8'hff);
    endtask

    task automatic random_frames(int unsigned count);
        logic [31:0] word;
        for (int unsigned i = 0; i < count; i++) begin
            word = next_random();
            run_frame("random", word[31:24], opcode_from_index(word[18:16]), word[15:8]);
        end
    endtask

    task automatic unknown_opcodes();
        run_frame("unknown", 8'h3c, 8'h55, 8'h0f);
        run_frame("unknown", 8'hff, 8'hff, 8'hff);
    endtask

    task automatic bad_stop_recovery();
        send_byte(8'h5a, 1'b0); // Framing error.
        send_bit(1'b1);
        send_bit(1'b1);
        run_frame("after bad stop", 8'h12, op_add, 8'h34);
    endtask

    task automatic back_to_back_frames(int unsigned count);
        logic [31:0] word;
        for (int unsigned i = 0; i < count; i++) begin
            word = next_random();
            run_frame("back to back", word[23:16], opcode_from_index(word[10:8]), word[7:0]);
        end
    endtask

    initial begin
        rx    = 1'b1;
        reset = 1'b0;
        repeat (2) @(posedge clock);
        #(drive_delay);
        reset = 1'b1;

        check_reset_state();
        opcode_sweep();
        random_frames(20);
        unknown_opcodes();
        bad_stop_recovery();
        back_to_back_frames(6);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
